/* tb.f */
mem_system_pkg.sv
cache_if.sv
cache_array.sv
four_bank_mem.sv
mem_system_control.sv
mem_system.sv
tb_mem_system.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the memory system testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_mem_system \
  --Mdir obj_dir -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

# The log decides the result
if grep -q "TEST FAIL" "$log"; then
  exit 1
fi
exit 0

/* tb_mem_system.sv */
`default_nettype none

module tb_mem_system import mem_system_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int wait_limit = 100;

  logic        clk;
  logic        reset;
  mem_addr_u   addr;
  logic [15:0] data_in;
  logic        rd;
  logic        wr;
  logic [15:0] data_out;
  logic        done;
  logic        stall;
  logic        cache_hit;
  logic        err;

  // Reference model: flat word memory plus direct-mapped tag state
  logic [15:0]          model_mem [32768];
  logic [tag_w-1:0]     model_tag [num_lines];
  logic [num_lines-1:0] model_valid;
  logic [num_lines-1:0] model_dirty;

  int checks;
  int errors;

  mem_system u_dut (
    .clk      (clk),
    .reset    (reset),
    .Addr     (addr),
    .DataIn   (data_in),
    .Rd       (rd),
    .Wr       (wr),
    .DataOut  (data_out),
    .Done     (done),
    .Stall    (stall),
    .CacheHit (cache_hit),
    .err      (err)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_data(input string name, input logic [15:0] exp, input logic [15:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input mem_addr_u exp, input mem_addr_u act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("ERROR %s: expected %h (tag %0d index %0d), actual %h (tag %0d index %0d)",
               name, exp, exp.cache.tag, exp.cache.index,
               act, act.cache.tag, act.cache.index);
    end
  endtask

  // Aligned address in a small window so lines conflict and hit often
  function automatic mem_addr_u rand_addr();
    mem_addr_u a;
    a = '0;
    a.cache.tag    = tag_w'($urandom_range(3, 0));
    a.cache.index  = index_w'($urandom_range(7, 0));
    a.cache.offset = {2'($urandom_range(3, 0)), 1'b0};
    return a;
  endfunction

  // One host request, checked against the model, then the model is updated
  task automatic access(input string name, input mem_addr_u a, input logic [15:0] d,
                        input logic is_wr);
    logic [index_w-1:0] idx;
    logic               exp_hit;
    logic               exp_wb;
    logic               wb_seen;
    logic               got_done;
    mem_addr_u          wb_exp;
    mem_addr_u          wb_got;
    int                 cycles;
    idx     = a.cache.index;
    exp_hit = model_valid[idx] && (model_tag[idx] == a.cache.tag);
    exp_wb  = !exp_hit && model_valid[idx] && model_dirty[idx];
    wb_exp  = '0;
    wb_exp.cache.tag   = model_tag[idx];
    wb_exp.cache.index = idx;
    wb_seen  = 1'b0;
    wb_got   = '0;
    got_done = 1'b0;
    cycles   = 0;
    @(negedge clk);
    addr    = a;
    data_in = d;
    rd      = !is_wr;
    wr      = is_wr;
    while (!got_done && cycles < wait_limit) begin
      // Mid low phase, outputs settled for the coming edge
      #1;
      if (u_dut.mem_wr && !wb_seen) begin
        wb_seen = 1'b1;
        wb_got  = u_dut.mem_addr;
      end
      if (cycles == 1) begin
        check_flag({name, " stall"}, 1'b1, stall);
      end
      if (done) begin
        got_done = 1'b1;
        check_flag({name, " hit"}, exp_hit, cache_hit);
        if (!is_wr) begin
          check_data({name, " data"}, model_mem[a[15:1]], data_out);
        end
      end
      cycles++;
      @(negedge clk);
      rd = 1'b0;
      wr = 1'b0;
    end
    if (!got_done) begin
      errors++;
      $display("%s: no Done within %0d cycles for address %h", name, wait_limit, a);
    end else begin
      check_flag({name, " writeback"}, exp_wb, wb_seen);
      if (exp_wb && wb_seen) begin
        check_addr({name, " victim"}, wb_exp, wb_got);
      end
      if (!exp_hit) begin
        model_valid[idx] = 1'b1;
        model_tag[idx]   = a.cache.tag;
        model_dirty[idx] = 1'b0;
      end
      if (is_wr) begin
        model_mem[a[15:1]] = d;
        model_dirty[idx]   = 1'b1;
      end
    end
  endtask

  // Illegal request: err in the same cycle, no Done, FSM stays idle
  task automatic bad_request(input string name, input mem_addr_u a, input logic rd_v,
                             input logic wr_v);
    @(negedge clk);
    addr    = a;
    data_in = 16'($urandom);
    rd      = rd_v;
    wr      = wr_v;
    #1;
    check_flag({name, " err"}, 1'b1, err);
    check_flag({name, " done"}, 1'b0, done);
    @(negedge clk);
    rd = 1'b0;
    wr = 1'b0;
    #1;
    check_flag({name, " stall"}, 1'b0, stall);
    check_flag({name, " late done"}, 1'b0, done);
  endtask

  task automatic report_test(input string name, input int start);
    $display("test %-10s finished with %0d errors", name, errors - start);
  endtask

  initial begin
    mem_addr_u   a;
    mem_addr_u   b;
    logic [15:0] d;
    int          start;
    void'($urandom(32'hd556));
    addr    = '0;
    data_in = '0;
    rd      = 1'b0;
    wr      = 1'b0;
    reset   = 1'b1;
    checks  = 0;
    errors  = 0;
    for (int i = 0; i < 32768; i++) begin
      model_mem[i] = '0;
    end
    for (int i = 0; i < num_lines; i++) begin
      model_tag[i] = '0;
    end
    model_valid = '0;
    model_dirty = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Outputs idle after reset, first accesses all miss
    start = errors;
    #1;
    check_flag("reset done", 1'b0, done);
    check_flag("reset stall", 1'b0, stall);
    check_flag("reset hit", 1'b0, cache_hit);
    check_flag("reset err", 1'b0, err);
    for (int i = 0; i < 4; i++) begin
      a = 16'($urandom) & 16'hfffe;
      access("cold", a, '0, 1'b0);
    end
    report_test("reset", start);

    start = errors;
    for (int i = 0; i < 400; i++) begin
      access("random", rand_addr(), 16'($urandom), 1'($urandom_range(1, 0)));
    end
    report_test("random", start);

    // Dirty line pushed out by conflicting tags, then read back
    start = errors;
    a = '0;
    a.cache.tag   = 5'd1;
    a.cache.index = 8'd200;
    b = a;
    d = 16'($urandom);
    access("evict", a, d, 1'b1);
    b.cache.tag = 5'd2;
    access("evict", b, '0, 1'b0);
    b.cache.tag = 5'd3;
    access("evict", b, 16'($urandom), 1'b1);
    access("evict", a, '0, 1'b0);
    report_test("evict", start);

    // Build a line in memory, evict it, then one miss must fill all words
    start = errors;
    a = '0;
    a.cache.tag   = 5'd9;
    a.cache.index = 8'd100;
    for (int i = 0; i < words_per_line; i++) begin
      a.cache.offset = {i[1:0], 1'b0};
      access("fill", a, 16'($urandom), 1'b1);
    end
    b = a;
    b.cache.tag = 5'd10;
    access("fill", b, '0, 1'b0);
    a.cache.offset = 3'b100;
    access("fill", a, '0, 1'b0);
    for (int i = 0; i < words_per_line; i++) begin
      a.cache.offset = {i[1:0], 1'b0};
      access("fill", a, '0, 1'b0);
    end
    report_test("fill", start);

    start = errors;
    a = rand_addr();
    access("error", a, 16'($urandom), 1'b1);
    b = a;
    b.cache.offset[0] = 1'b1;
    bad_request("odd_read", b, 1'b1, 1'b0);
    bad_request("odd_write", b, 1'b0, 1'b1);
    bad_request("rd_and_wr", a, 1'b1, 1'b1);
    access("error", a, '0, 1'b0);
    b = rand_addr();
    b.cache.index = 8'd50;
    bad_request("rd_and_wr", b, 1'b1, 1'b1);
    access("error", b, '0, 1'b0);
    report_test("error", start);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* mem_system.sv */
`default_nettype none

module mem_system import mem_system_pkg::*; (
  input wire          clk,
  input wire          reset,
  input wire [15:0]   Addr,
  input wire [15:0]   DataIn,
  input wire          Rd,
  input wire          Wr,
  output logic [15:0] DataOut,
  output logic        Done,
  output logic        Stall,
  output logic        CacheHit,
  output logic        err
);

  // Controller to memory
  mem_addr_u   mem_addr;
  logic [15:0] mem_data_in;
  logic        mem_rd;
  logic        mem_wr;

  // Memory back to controller
  logic [15:0] mem_data_out;
  logic        mem_stall;
  logic        mem_err;

  logic        ctl_err;

  cache_if cif ();

  mem_system_control u_ctl (
    .clk          (clk),
    .reset        (reset),
    .req_addr     (Addr),
    .req_data     (DataIn),
    .rd           (Rd),
    .wr           (Wr),
    .cif          (cif.ctrl),
    .mem_addr     (mem_addr),
    .mem_data_in  (mem_data_in),
    .mem_rd       (mem_rd),
    .mem_wr       (mem_wr),
    .mem_data_out (mem_data_out),
    .mem_stall    (mem_stall),
    .done         (Done),
    .stall        (Stall),
    .cache_hit    (CacheHit),
    .ctl_err      (ctl_err)
  );

  cache_array u_cache (
    .clk   (clk),
    .reset (reset),
    .cif   (cif.array)
  );

  four_bank_mem u_mem (
    .clk          (clk),
    .reset        (reset),
    .mem_addr     (mem_addr),
    .mem_data_in  (mem_data_in),
    .mem_rd       (mem_rd),
    .mem_wr       (mem_wr),
    .mem_data_out (mem_data_out),
    .mem_stall    (mem_stall),
    .mem_err      (mem_err)
  );

  // Read data is the cache word addressed by the host
  assign DataOut = cif.data_out;
  assign err     = ctl_err | mem_err;

endmodule

`default_nettype wire

/* mem_system_control.sv */
`default_nettype none

module mem_system_control import mem_system_pkg::*; (
  input wire            clk,
  input wire            reset,
  input wire mem_addr_u req_addr,
  input wire [15:0]     req_data,
  input wire            rd,
  input wire            wr,
  cache_if.ctrl         cif,
  output mem_addr_u     mem_addr,
  output logic [15:0]   mem_data_in,
  output logic          mem_rd,
  output logic          mem_wr,
  input wire [15:0]     mem_data_out,
  input wire            mem_stall,
  output logic          done,
  output logic          stall,
  output logic          cache_hit,
  output logic          ctl_err
);

  ctl_state_e                  state;
  logic [cnt_w-1:0]            cnt;
  logic [cnt_w-1:0]            got_cnt;
  logic                        is_wr;
  logic                        req;
  logic                        req_ok;
  logic                        last_word;
  logic                        issue;
  logic [mem_read_latency-1:0] pend_vld;
  logic [word_sel_w-1:0]       pend_word [mem_read_latency];
  logic                        fill_vld;
  logic [word_sel_w-1:0]       fill_word;
  logic [word_sel_w-1:0]       cur_word;

  assign req     = rd | wr;
  assign ctl_err = (rd & wr) | (req & req_addr.cache.offset[0]);
  assign req_ok  = req & ~ctl_err & (state == st_idle);

  assign cur_word  = cnt[word_sel_w-1:0];
  assign last_word = (cur_word == word_sel_w'(words_per_line - 1));
  assign issue     = mem_rd & ~mem_stall;
  assign fill_vld  = pend_vld[mem_read_latency-1];
  assign fill_word = pend_word[mem_read_latency-1];

  assign stall     = (state != st_idle);
  assign cache_hit = req_ok & cif.hit;
  assign done      = cache_hit | (state == st_final);

  // Write-back data comes straight from the victim line
  assign mem_data_in = cif.data_out;

  // Victim address during write-back, otherwise the requested line
  always_comb begin
    if (state == st_writeback) begin
      mem_addr = {cif.tag_out, req_addr.cache.index, cur_word, 1'b0};
    end else begin
      mem_addr = {req_addr.cache.tag, req_addr.cache.index, cur_word, 1'b0};
    end
  end

  // Cache request and memory strobes
  always_comb begin
    cif.enable  = 1'b0;
    cif.tag_in  = req_addr.cache.tag;
    cif.index   = req_addr.cache.index;
    cif.offset  = req_addr.cache.offset;
    cif.data_in = req_data;
    cif.comp    = 1'b0;
    cif.write   = 1'b0;
    mem_rd      = 1'b0;
    mem_wr      = 1'b0;
    case (state)
      st_idle: begin
        cif.enable = req_ok;
        cif.comp   = 1'b1;
        cif.write  = req_ok & wr;
      end
      st_compare: begin
        cif.enable = 1'b1;
      end
      st_writeback: begin
        cif.enable = 1'b1;
        cif.offset = {cur_word, 1'b0};
        mem_wr     = 1'b1;
      end
      st_fill_req: begin
        mem_rd = 1'b1;
      end
      st_final: begin
        cif.enable = 1'b1;
        cif.comp   = 1'b1;
        cif.write  = is_wr;
      end
      default: begin
      end
    endcase
    // Returning fill word
    if (fill_vld) begin
      cif.enable  = 1'b1;
      cif.offset  = {fill_word, 1'b0};
      cif.data_in = mem_data_out;
      cif.comp    = 1'b0;
      cif.write   = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= st_idle;
      cnt      <= '0;
      got_cnt  <= '0;
      is_wr    <= 1'b0;
      pend_vld <= '0;
    end else begin
      pend_vld <= {pend_vld[mem_read_latency-2:0], issue};
      if (fill_vld) begin
        got_cnt <= got_cnt + 1'b1;
      end
      case (state)
        st_idle: begin
          cnt     <= '0;
          got_cnt <= '0;
          if (req_ok && !cif.hit) begin
            is_wr <= wr;
            state <= st_compare;
          end
        end
        st_compare: begin
          state <= (cif.valid && cif.dirty) ? st_writeback : st_fill_req;
        end
        st_writeback: begin
          if (!mem_stall) begin
            cnt <= cnt + 1'b1;
            if (last_word) begin
              cnt   <= '0;
              state <= st_wb_drain;
            end
          end
        end
        // Let every bank go idle before the fill starts
        st_wb_drain: begin
          cnt <= cnt + 1'b1;
          if (cnt == cnt_w'(bank_cycles - 1)) begin
            cnt   <= '0;
            state <= st_fill_req;
          end
        end
        st_fill_req: begin
          if (!mem_stall) begin
            cnt <= cnt + 1'b1;
            if (last_word) begin
              state <= st_fill_wait;
            end
          end
        end
        st_fill_wait: begin
          if (got_cnt == cnt_w'(words_per_line)) begin
            state <= st_final;
          end
        end
        st_final: begin
          state <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // Tracks which word each read in flight belongs to
  always_ff @(posedge clk) begin
    pend_word[0] <= cur_word;
    for (int i = 1; i < mem_read_latency; i++) begin
      pend_word[i] <= pend_word[i-1];
    end
  end

  a_rd_wr_excl: assert property (
    @(posedge clk) disable iff (reset)
    !(mem_rd && mem_wr)
  );

  // After a fill the replayed access must find its line
  a_final_hits: assert property (
    @(posedge clk) disable iff (reset)
    (state == st_final) |-> cif.hit
  );

endmodule

`default_nettype wire

/* four_bank_mem.sv */
`default_nettype none

module four_bank_mem import mem_system_pkg::*; (
  input wire            clk,
  input wire            reset,
  input wire mem_addr_u mem_addr,
  input wire [15:0]     mem_data_in,
  input wire            mem_rd,
  input wire            mem_wr,
  output logic [15:0]   mem_data_out,
  output logic          mem_stall,
  output logic          mem_err
);

  // Contents start at zero
  logic [15:0] bank_mem [num_banks][bank_depth] = '{default: '0};

  logic [busy_w-1:0]    busy_cnt [num_banks];
  logic [num_banks-1:0] bank_busy;
  logic [num_banks-1:0] bank_acc;
  logic [bank_w-1:0]    sel;
  logic [row_w-1:0]     row;
  logic                 req;
  logic                 accept;
  logic [15:0]          rd_pipe [mem_read_latency];

  // Low address bits interleave words across the banks
  assign sel = mem_addr.mem.bank;
  assign row = mem_addr.mem.row;
  assign req = mem_rd | mem_wr;

  assign mem_err   = (mem_rd & mem_wr) | (req & mem_addr.mem.byte_sel);
  assign mem_stall = req & bank_busy[sel];
  assign accept    = req & ~bank_busy[sel] & ~mem_err;

  assign mem_data_out = rd_pipe[mem_read_latency-1];

  for (genvar b = 0; b < num_banks; b++) begin : g_bank
    assign bank_busy[b] = (busy_cnt[b] != '0);
    assign bank_acc[b]  = accept && (sel == bank_w'(b));

    // Busy timer, reloaded on every accepted access
    always_ff @(posedge clk) begin
      if (reset) begin
        busy_cnt[b] <= '0;
      end else if (bank_acc[b]) begin
        busy_cnt[b] <= busy_w'(bank_cycles);
      end else if (bank_busy[b]) begin
        busy_cnt[b] <= busy_cnt[b] - 1'b1;
      end
    end

    // Two accesses to one bank are at least bank_cycles + 1 apart
    for (genvar k = 1; k <= bank_cycles; k++) begin : g_gap
      a_bank_gap: assert property (
        @(posedge clk) disable iff (reset)
        bank_acc[b] |-> !$past(bank_acc[b], k)
      );
    end
  end

  always_ff @(posedge clk) begin
    if (accept && mem_wr) begin
      bank_mem[sel][row] <= mem_data_in;
    end
  end

  // Read data pipeline, several reads may be in flight
  always_ff @(posedge clk) begin
    rd_pipe[0] <= bank_mem[sel][row];
    for (int i = 1; i < mem_read_latency; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

endmodule

`default_nettype wire

/* cache_array.sv */
`default_nettype none

module cache_array import mem_system_pkg::*; (
  input wire      clk,
  input wire      reset,
  cache_if.array  cif
);

  logic [tag_w-1:0]      tag_mem  [num_lines];
  logic [15:0]           data_mem [num_lines][words_per_line];
  logic [num_lines-1:0]  valid_q;
  logic [num_lines-1:0]  dirty_q;
  logic [word_sel_w-1:0] word;
  logic                  tag_match;
  logic                  fill_wr;
  logic                  upd_wr;

  // Byte bit is dropped, the rest picks the word in the line
  assign word = cif.offset[offset_w-1:1];

  // Combinational read of the indexed line
  assign cif.tag_out  = tag_mem[cif.index];
  assign cif.valid    = valid_q[cif.index];
  assign cif.dirty    = dirty_q[cif.index];
  assign cif.data_out = data_mem[cif.index][word];

  assign tag_match = (tag_mem[cif.index] == cif.tag_in);
  assign cif.hit   = cif.enable & cif.comp & cif.valid & tag_match;

  // Fill mode writes regardless of tag, compare mode only on a hit
  assign fill_wr = cif.enable & cif.write & ~cif.comp;
  assign upd_wr  = cif.enable & cif.write & cif.hit;

  always_ff @(posedge clk) begin
    if (fill_wr) begin
      tag_mem[cif.index] <= cif.tag_in;
    end
    if (fill_wr || upd_wr) begin
      data_mem[cif.index][word] <= cif.data_in;
    end
  end

  // Line status
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else if (fill_wr) begin
      valid_q[cif.index] <= 1'b1;
      dirty_q[cif.index] <= 1'b0;
    end else if (upd_wr) begin
      dirty_q[cif.index] <= 1'b1;
    end
  end

  // Controller must never write a line it has not enabled
  a_write_needs_enable: assert property (
    @(posedge clk) disable iff (reset)
    cif.write |-> cif.enable
  );

endmodule

`default_nettype wire

/* cache_if.sv */
`default_nettype none

interface cache_if import mem_system_pkg::*; ();

  // Request side
  logic                enable;
  logic [tag_w-1:0]    tag_in;
  logic [index_w-1:0]  index;
  logic [offset_w-1:0] offset;
  logic [15:0]         data_in;
  logic                comp;
  logic                write;

  // Response side
  logic [tag_w-1:0]    tag_out;
  logic [15:0]         data_out;
  logic                hit;
  logic                dirty;
  logic                valid;

  modport ctrl (
    output enable, tag_in, index, offset, data_in, comp, write,
    input  tag_out, data_out, hit, dirty, valid
  );

  modport array (
    input  enable, tag_in, index, offset, data_in, comp, write,
    output tag_out, data_out, hit, dirty, valid
  );

endinterface

`default_nettype wire

/* mem_system_pkg.sv */
`default_nettype none

package mem_system_pkg;

  // Address fields as seen by the cache
  localparam int tag_w = 5;
  localparam int index_w = 8;
  localparam int offset_w = 3;

  // Cache geometry
  localparam int words_per_line = 4;
  localparam int num_lines = 2 ** index_w;
  localparam int word_sel_w = $clog2(words_per_line);
  localparam int cnt_w = word_sel_w + 1;

  // Main memory geometry and timing
  localparam int num_banks = 4;
  localparam int bank_w = $clog2(num_banks);
  localparam int row_w = 13;
  localparam int bank_depth = 2 ** row_w;
  localparam int bank_cycles = 4;
  localparam int busy_w = $clog2(bank_cycles + 1);
  localparam int mem_read_latency = 2;

  // One byte address, split for the cache or for the banks
  typedef union packed {
    struct packed {
      logic [tag_w-1:0]    tag;
      logic [index_w-1:0]  index;
      logic [offset_w-1:0] offset;
    } cache;
    struct packed {
      logic [row_w-1:0]  row;
      logic [bank_w-1:0] bank;
      logic              byte_sel;
    } mem;
  } mem_addr_u;

  typedef enum logic [2:0] {
    st_idle,
    st_compare,
    st_writeback,
    st_wb_drain,
    st_fill_req,
    st_fill_wait,
    st_final
  } ctl_state_e;

endpackage

`default_nettype wire
